// File: Bender.yml
package:
  name: frontend

sources:
  # packages first, top level last
  - rtl/rv_pkg.sv
  - rtl/bp_pkg.sv
  - rtl/gshare_predictor.sv
  - rtl/fetch_unit.sv
  - rtl/fetch_pipe.sv
  - rtl/branch_resolve.sv
  - rtl/frontend_top.sv
  - target: test
    files:
      - verification/frontend_props.sv
      - verification/frontend_tb.sv

// File: project.f
rtl/rv_pkg.sv
rtl/bp_pkg.sv
rtl/gshare_predictor.sv
rtl/fetch_unit.sv
rtl/fetch_pipe.sv
rtl/branch_resolve.sv
rtl/frontend_top.sv
verification/frontend_props.sv
verification/frontend_tb.sv

// File: rtl/bp_pkg.sv
// branch predictor types
// counter states, table index helpers and BTB entry fields

package bp_pkg;

  typedef enum logic [1:0] {
    STRONG_NT = 2'b00,
    WEAK_NT   = 2'b01,  // reset state
    WEAK_T    = 2'b10,
    STRONG_T  = 2'b11
  } ctr_state_t;

  typedef rv_pkg::addr_t btb_tag_t;     // full pc as tag
  typedef rv_pkg::addr_t btb_target_t;  // stored jump/branch target

  localparam int DEFAULT_GHR_BITS    = 4;
  localparam int DEFAULT_BTB_ENTRIES = 16;

  // word index of a pc, bits above bit 1
  function automatic rv_pkg::addr_t pc_bits(input rv_pkg::addr_t pc);
    return pc >> 2;
  endfunction

  // gshare hash, caller keeps the low bits it needs
  function automatic rv_pkg::addr_t gshare_hash(input rv_pkg::addr_t pc,
                                                input rv_pkg::addr_t hist);
    return pc_bits(pc) ^ hist;
  endfunction

endpackage

// File: rtl/branch_resolve.sv
// execute-stage resolve, real next pc against the prediction
// drives redirect, retire and the predictor update

`timescale 1ns/1ps

module branch_resolve (
  input  logic               resolve_valid,
  input  rv_pkg::addr_t      resolve_pc,
  input  rv_pkg::addr_t      resolve_pred_pc,
  input  rv_pkg::ctrl_kind_t ex_kind,
  input  logic               ex_taken,
  input  rv_pkg::addr_t      ex_target,
  output logic               redirect,
  output rv_pkg::addr_t      redirect_pc,
  output logic               update_valid,
  output rv_pkg::addr_t      update_pc,
  output rv_pkg::ctrl_kind_t update_kind,
  output logic               update_taken,
  output rv_pkg::addr_t      update_target,
  output logic               retire_valid,
  output rv_pkg::addr_t      retire_pc,
  output logic               mispredict
);

  logic          is_jump;
  logic          take_target;
  rv_pkg::addr_t actual_next;

  assign is_jump     = (ex_kind == rv_pkg::KIND_JAL) || (ex_kind == rv_pkg::KIND_JALR);
  assign take_target = is_jump || (ex_kind == rv_pkg::KIND_BRANCH && ex_taken);
  assign actual_next = take_target ? ex_target : resolve_pc + rv_pkg::INST_BYTES;

  assign mispredict  = resolve_valid && (actual_next != resolve_pred_pc);
  assign redirect    = mispredict;   // flush and refetch
  assign redirect_pc = actual_next;

  assign retire_valid = resolve_valid;  // every valid item retires
  assign retire_pc    = resolve_pc;

  // train on every control-flow item
  assign update_valid  = resolve_valid && (ex_kind != rv_pkg::KIND_PLAIN);
  assign update_pc     = resolve_pc;
  assign update_kind   = ex_kind;
  assign update_taken  = take_target;   // jumps count as taken
  assign update_target = ex_target;

endmodule

// File: rtl/fetch_pipe.sv
// IF/ID and ID/EX pc registers with valid bits
// a redirect invalidates both stages so wrong-path items never resolve

`timescale 1ns/1ps

module fetch_pipe (
  input  logic          clk,
  input  logic          reset,
  input  logic          redirect,
  input  rv_pkg::addr_t fetch_pc,
  input  rv_pkg::addr_t pred_pc,
  output logic          resolve_valid,
  output rv_pkg::addr_t resolve_pc,
  output rv_pkg::addr_t resolve_pred_pc
);

  localparam int STAGES = 2;  // IF/ID, ID/EX

  logic [STAGES-1:0] valid_q;
  rv_pkg::addr_t     pc_q   [STAGES];
  rv_pkg::addr_t     pred_q [STAGES];

  // valid bits, flush has priority over the new fetch
  always_ff @(posedge clk) begin
    if (reset || redirect) begin
      valid_q <= '0;
    end else begin
      valid_q <= {valid_q[STAGES-2:0], 1'b1};  // fetch always has an item
    end
  end

  // pc payload shifts every cycle, no stall
  always_ff @(posedge clk) begin
    pc_q[0]   <= fetch_pc;
    pred_q[0] <= pred_pc;
    for (int i = 1; i < STAGES; i++) begin
      pc_q[i]   <= pc_q[i-1];
      pred_q[i] <= pred_q[i-1];
    end
  end

  assign resolve_valid   = valid_q[STAGES-1];
  assign resolve_pc      = pc_q[STAGES-1];
  assign resolve_pred_pc = pred_q[STAGES-1];

endmodule

// File: rtl/fetch_unit.sv
// fetch stage, pc register with the gshare predictor
// next pc is the redirect target or the prediction for the current pc

`timescale 1ns/1ps

module fetch_unit #(
  parameter int GHR_BITS    = bp_pkg::DEFAULT_GHR_BITS,
  parameter int BTB_ENTRIES = bp_pkg::DEFAULT_BTB_ENTRIES
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               redirect,       // resolve found a mispredict
  input  rv_pkg::addr_t      redirect_pc,
  input  logic               update_valid,
  input  rv_pkg::addr_t      update_pc,
  input  rv_pkg::ctrl_kind_t update_kind,
  input  logic               update_taken,
  input  rv_pkg::addr_t      update_target,
  output rv_pkg::addr_t      fetch_pc,
  output rv_pkg::addr_t      pred_pc         // prediction made for fetch_pc
);

  gshare_predictor #(
    .GHR_BITS    (GHR_BITS),
    .BTB_ENTRIES (BTB_ENTRIES)
  ) u_predictor (
    .clk           (clk),
    .reset         (reset),
    .lookup_pc     (fetch_pc),
    .update_valid  (update_valid),
    .update_pc     (update_pc),
    .update_kind   (update_kind),
    .update_taken  (update_taken),
    .update_target (update_target),
    .pred_pc       (pred_pc)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      fetch_pc <= rv_pkg::RESET_PC;
    end else if (redirect) begin
      fetch_pc <= redirect_pc;  // redirect wins over prediction
    end else begin
      fetch_pc <= pred_pc;
    end
  end

endmodule

// File: rtl/frontend_top.sv
// control-flow front end: fetch with gshare, two pc stages, resolve
// execute results come in as levels for the item at resolve

`timescale 1ns/1ps

module frontend_top #(
  parameter int GHR_BITS    = bp_pkg::DEFAULT_GHR_BITS,
  parameter int BTB_ENTRIES = bp_pkg::DEFAULT_BTB_ENTRIES
) (
  input  logic               clk,
  input  logic               reset,
  input  rv_pkg::ctrl_kind_t ex_kind,
  input  logic               ex_taken,
  input  rv_pkg::addr_t      ex_target,
  output rv_pkg::addr_t      fetch_pc,
  output logic               retire_valid,
  output rv_pkg::addr_t      retire_pc,
  output logic               mispredict
);

  rv_pkg::addr_t      pred_pc;
  logic               redirect;
  rv_pkg::addr_t      redirect_pc;
  logic               resolve_valid;
  rv_pkg::addr_t      resolve_pc, resolve_pred_pc;
  logic               update_valid, update_taken;
  rv_pkg::addr_t      update_pc, update_target;
  rv_pkg::ctrl_kind_t update_kind;

  fetch_unit #(
    .GHR_BITS    (GHR_BITS),
    .BTB_ENTRIES (BTB_ENTRIES)
  ) u_fetch (
    .clk           (clk),
    .reset         (reset),
    .redirect      (redirect),
    .redirect_pc   (redirect_pc),
    .update_valid  (update_valid),
    .update_pc     (update_pc),
    .update_kind   (update_kind),
    .update_taken  (update_taken),
    .update_target (update_target),
    .fetch_pc      (fetch_pc),
    .pred_pc       (pred_pc)
  );

  fetch_pipe u_pipe (
    .clk             (clk),
    .reset           (reset),
    .redirect        (redirect),
    .fetch_pc        (fetch_pc),
    .pred_pc         (pred_pc),
    .resolve_valid   (resolve_valid),
    .resolve_pc      (resolve_pc),
    .resolve_pred_pc (resolve_pred_pc)
  );

  branch_resolve u_resolve (
    .resolve_valid   (resolve_valid),
    .resolve_pc      (resolve_pc),
    .resolve_pred_pc (resolve_pred_pc),
    .ex_kind         (ex_kind),
    .ex_taken        (ex_taken),
    .ex_target       (ex_target),
    .redirect        (redirect),
    .redirect_pc     (redirect_pc),
    .update_valid    (update_valid),
    .update_pc       (update_pc),
    .update_kind     (update_kind),
    .update_taken    (update_taken),
    .update_target   (update_target),
    .retire_valid    (retire_valid),
    .retire_pc       (retire_pc),
    .mispredict      (mispredict)
  );

endmodule

// File: rtl/gshare_predictor.sv
// gshare direction predictor with a tagged branch target buffer
// combinational lookup, table writes on the edge after an update

`timescale 1ns/1ps

module gshare_predictor #(
  parameter int GHR_BITS    = bp_pkg::DEFAULT_GHR_BITS,
  parameter int BTB_ENTRIES = bp_pkg::DEFAULT_BTB_ENTRIES
) (
  input  logic               clk,
  input  logic               reset,
  input  rv_pkg::addr_t      lookup_pc,
  input  logic               update_valid,
  input  rv_pkg::addr_t      update_pc,
  input  rv_pkg::ctrl_kind_t update_kind,
  input  logic               update_taken,
  input  rv_pkg::addr_t      update_target,
  output rv_pkg::addr_t      pred_pc
);

  localparam int PHT_ENTRIES  = 1 << GHR_BITS;
  localparam int BTB_IDX_BITS = $clog2(BTB_ENTRIES);

  logic [GHR_BITS-1:0]     ghr;         // global history, newest in bit 0
  bp_pkg::ctr_state_t      pht [PHT_ENTRIES];
  logic [BTB_ENTRIES-1:0]  btb_valid;
  bp_pkg::btb_tag_t        btb_tag [BTB_ENTRIES];
  bp_pkg::btb_target_t     btb_target [BTB_ENTRIES];
  rv_pkg::ctrl_kind_t      btb_kind [BTB_ENTRIES];

  rv_pkg::addr_t           lk_word, lk_hash, up_word, up_hash;
  logic [GHR_BITS-1:0]     lk_pht_idx, up_pht_idx;
  logic [BTB_IDX_BITS-1:0] lk_btb_idx, up_btb_idx;
  logic                    btb_hit, is_jump, ctr_taken;
  logic                    is_branch_upd, btb_write;
  bp_pkg::ctr_state_t      ctr_cur, ctr_next;

  // lookup side
  assign lk_word    = bp_pkg::pc_bits(lookup_pc);
  assign lk_hash    = bp_pkg::gshare_hash(lookup_pc, rv_pkg::addr_t'(ghr));
  assign lk_pht_idx = lk_hash[GHR_BITS-1:0];
  assign lk_btb_idx = lk_word[BTB_IDX_BITS-1:0];

  assign btb_hit   = btb_valid[lk_btb_idx] && (btb_tag[lk_btb_idx] == lookup_pc);
  assign is_jump   = btb_kind[lk_btb_idx] != rv_pkg::KIND_BRANCH;  // jal or jalr entry
  assign ctr_taken = pht[lk_pht_idx] inside {bp_pkg::WEAK_T, bp_pkg::STRONG_T};

  assign pred_pc = (btb_hit && (is_jump || ctr_taken)) ? btb_target[lk_btb_idx]
                                                       : lookup_pc + rv_pkg::INST_BYTES;

  // update side
  assign up_word    = bp_pkg::pc_bits(update_pc);
  assign up_hash    = bp_pkg::gshare_hash(update_pc, rv_pkg::addr_t'(ghr));
  assign up_pht_idx = up_hash[GHR_BITS-1:0];
  assign up_btb_idx = up_word[BTB_IDX_BITS-1:0];

  assign is_branch_upd = update_valid && (update_kind == rv_pkg::KIND_BRANCH);
  assign btb_write     = update_valid && (update_kind != rv_pkg::KIND_BRANCH || update_taken);
  assign ctr_cur       = pht[up_pht_idx];

  always_comb begin
    ctr_next = ctr_cur;  // saturate at both ends
    case (ctr_cur)
      bp_pkg::STRONG_NT: ctr_next = update_taken ? bp_pkg::WEAK_NT : bp_pkg::STRONG_NT;
      bp_pkg::WEAK_NT:   ctr_next = update_taken ? bp_pkg::WEAK_T : bp_pkg::STRONG_NT;
      bp_pkg::WEAK_T:    ctr_next = update_taken ? bp_pkg::STRONG_T : bp_pkg::WEAK_NT;
      bp_pkg::STRONG_T:  ctr_next = update_taken ? bp_pkg::STRONG_T : bp_pkg::WEAK_T;
      default:           ctr_next = bp_pkg::WEAK_NT;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      ghr       <= '0;
      btb_valid <= '0;
      for (int i = 0; i < PHT_ENTRIES; i++) begin
        pht[i] <= bp_pkg::WEAK_NT;
      end
    end else begin
      if (is_branch_upd) begin
        pht[up_pht_idx] <= ctr_next;
        ghr             <= {ghr[GHR_BITS-2:0], update_taken};  // shift in outcome
      end
      if (btb_write) begin
        btb_valid[up_btb_idx] <= 1'b1;
      end
    end
  end

  // btb payload, qualified by btb_valid
  always_ff @(posedge clk) begin
    if (btb_write) begin
      btb_tag[up_btb_idx]    <= update_pc;
      btb_target[up_btb_idx] <= update_target;
      btb_kind[up_btb_idx]   <= update_kind;
    end
  end

endmodule

// File: rtl/rv_pkg.sv
// architectural types shared by the front end
// addresses, control-flow kinds and pc constants

package rv_pkg;

  typedef logic [31:0] addr_t;    // byte address or pc
  typedef logic [1:0] ctrl_kind_t;  // kind of a resolved instruction

  localparam ctrl_kind_t KIND_PLAIN  = 2'd0;  // not control flow
  localparam ctrl_kind_t KIND_BRANCH = 2'd1;  // conditional
  localparam ctrl_kind_t KIND_JAL    = 2'd2;  // direct jump
  localparam ctrl_kind_t KIND_JALR   = 2'd3;  // indirect jump

  localparam addr_t INST_BYTES = 32'd4;  // pc step
  localparam addr_t RESET_PC   = 32'd0;

endpackage

// File: verification/frontend_props.sv
// timing rules on the front end outputs, bound into frontend_top
// flush bubble after a mispredict and no unknown outputs out of reset

`timescale 1ns/1ps

module frontend_props (
  input logic          clk,
  input logic          reset,
  input rv_pkg::addr_t fetch_pc,
  input logic          retire_valid,
  input rv_pkg::addr_t retire_pc,
  input logic          mispredict
);

  int fail_count = 0;  // assertion failures so far

  // mispredict only on a retiring item
  mp_needs_retire: assert property (@(posedge clk) disable iff (reset)
    mispredict |-> retire_valid)
    else begin
      fail_count++;
      $error("mispredict raised without a retire");
    end

  // both pc stages flushed, two empty cycles
  mp_bubble: assert property (@(posedge clk) disable iff (reset)
    mispredict |=> !retire_valid ##1 !retire_valid)
    else begin
      fail_count++;
      $error("retire within two cycles of a mispredict");
    end

  outputs_known: assert property (@(posedge clk) disable iff (reset)
    !$isunknown({fetch_pc, retire_valid, retire_pc, mispredict}))
    else begin
      fail_count++;
      $error("unknown value on fetch_pc, retire_valid, retire_pc or mispredict");
    end

endmodule

bind frontend_top frontend_props u_props (
  .clk          (clk),
  .reset        (reset),
  .fetch_pc     (fetch_pc),
  .retire_valid (retire_valid),
  .retire_pc    (retire_pc),
  .mispredict   (mispredict)
);

// File: verification/frontend_stim.txt
// pc kind taken target mispredict, all hex, one correct-path instruction per line
// kind 0 plain, 1 branch, 2 jal, 3 jalr; last column is the expected mispredict at retire
00000000 0 0 00000000 0
00000004 1 1 00000004 1
00000004 1 1 00000004 1
00000004 1 1 00000004 1
00000004 1 1 00000004 1
00000004 1 1 00000004 1
00000004 1 1 00000004 0
00000004 1 1 00000004 0
00000004 1 1 00000004 0
00000004 1 1 00000004 0
00000004 1 1 00000004 0
00000004 1 1 00000004 0
00000004 1 0 00000004 1
00000008 1 0 00000020 0
0000000c 2 1 00000060 1
00000060 0 0 00000000 0
00000064 3 1 00000008 1
00000008 1 0 00000020 0
0000000c 2 1 00000060 0
00000060 0 0 00000000 0
00000064 3 1 00000008 0
00000008 1 0 00000020 0

// File: verification/frontend_tb.sv
// testbench for the control-flow front end
// replays an execute trace from a file, checks retire order, mispredicts and timing

`timescale 1ns/1ps

module frontend_tb;

  localparam int    MAX_TRACE    = 64;   // trace length limit
  localparam string STIM_FILE    = "verification/frontend_stim.txt";
  localparam int    CLK_PERIOD   = 100;
  localparam int    RESET_CYCLES = 5;
  localparam int    DRIVE_DELAY  = 1;    // ns after the rising edge
  localparam logic [31:0] SEED   = 32'h8986;

  logic               clk;
  logic               reset;
  rv_pkg::ctrl_kind_t ex_kind;
  logic               ex_taken;
  rv_pkg::addr_t      ex_target;
  rv_pkg::addr_t      fetch_pc;
  logic               retire_valid;
  rv_pkg::addr_t      retire_pc;
  logic               mispredict;

  rv_pkg::addr_t      tr_pc     [MAX_TRACE];
  rv_pkg::ctrl_kind_t tr_kind   [MAX_TRACE];
  logic               tr_taken  [MAX_TRACE];
  rv_pkg::addr_t      tr_target [MAX_TRACE];
  logic               tr_mp     [MAX_TRACE];  // expected mispredict

  int          trace_len;
  int          k;              // next expected entry
  int          cycle;          // cycles since reset release
  int          last_retire;
  logic        last_mp;
  int          value_errors;
  int          timing_errors;
  logic [31:0] lcg_state;
  bit          trace_loaded;

  frontend_top #(
    .GHR_BITS    (bp_pkg::DEFAULT_GHR_BITS),
    .BTB_ENTRIES (bp_pkg::DEFAULT_BTB_ENTRIES)
  ) UUT (
    .clk          (clk),
    .reset        (reset),
    .ex_kind      (ex_kind),
    .ex_taken     (ex_taken),
    .ex_target    (ex_target),
    .fetch_pc     (fetch_pc),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc),
    .mispredict   (mispredict)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic load_trace();
    int          fd;
    int          fields;
    string       line;
    logic [31:0] pc, kind, taken, target, mp;
    fd = $fopen(STIM_FILE, "r");
    if (fd != 0) begin
      while (!$feof(fd) && trace_len < MAX_TRACE) begin
        line = "";
        void'($fgets(line, fd));
        fields = $sscanf(line, "%h %h %h %h %h", pc, kind, taken, target, mp);
        if (fields == 5) begin  // header and blank lines give fewer fields
          tr_pc[trace_len]     = pc;
          tr_kind[trace_len]   = kind[1:0];
          tr_taken[trace_len]  = taken[0];
          tr_target[trace_len] = target;
          tr_mp[trace_len]     = mp[0];
          trace_len++;
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic print_counts();
    $display("errors: %0d value, %0d timing, %0d assertion, %0d total", value_errors,
             timing_errors, UUT.u_props.fail_count,
             value_errors + timing_errors + UUT.u_props.fail_count);
  endtask

  // nothing retires and nothing mispredicts
  task automatic check_idle();
    assert (retire_valid == 1'b0) else begin
      value_errors++;
      $display("ERR %0t retire_valid got %b expected 0", $time, retire_valid);
    end
    assert (mispredict == 1'b0) else begin
      value_errors++;
      $display("ERR %0t mispredict got %b expected 0", $time, mispredict);
    end
  endtask

  // execute levels for the item now at resolve
  task automatic drive_execute();
    lcg_state = lcg_next(lcg_state);
    if (retire_valid && k < trace_len && retire_pc == tr_pc[k]) begin
      ex_kind   = tr_kind[k];
      ex_taken  = tr_taken[k];
      ex_target = tr_target[k];
    end else begin
      ex_kind   = rv_pkg::KIND_PLAIN;
      ex_taken  = 1'b0;
      ex_target = lcg_state;  // junk, must be ignored
    end
  endtask

  task automatic check_retire();
    int gap_expected;
    gap_expected = (k == 0) ? 2 : (last_mp ? 3 : 1);  // fetch to resolve is 2 cycles
    assert (retire_pc == tr_pc[k]) else begin
      value_errors++;
      $display("ERR %0t retire_pc got %h expected %h", $time, retire_pc, tr_pc[k]);
    end
    assert (mispredict == tr_mp[k]) else begin
      value_errors++;
      $display("ERR %0t mispredict got %b expected %b", $time, mispredict, tr_mp[k]);
    end
    assert (cycle - last_retire == gap_expected) else begin
      timing_errors++;
      $display("retire of entry %0d came %0d cycles after the previous one, not %0d",
               k, cycle - last_retire, gap_expected);
    end
    last_retire = cycle;
    last_mp     = tr_mp[k];
    k++;
  endtask

  task automatic apply_reset();
    for (int i = 0; i < RESET_CYCLES; i++) begin
      @(posedge clk);
      #(DRIVE_DELAY);
      check_idle();
    end
    reset = 1'b0;
    drive_execute();
    @(negedge clk);
    assert (fetch_pc == rv_pkg::RESET_PC) else begin
      value_errors++;
      $display("ERR %0t fetch_pc got %h expected %h", $time, fetch_pc, rv_pkg::RESET_PC);
    end
    check_idle();
  endtask

  // drive after the edge, check at the falling edge
  task automatic run_trace();
    while (k < trace_len) begin
      @(posedge clk);
      #(DRIVE_DELAY);
      cycle++;
      drive_execute();
      @(negedge clk);
      if (retire_valid) begin
        check_retire();
      end else begin
        check_idle();
      end
    end
  endtask

  initial begin
    clk           = 1'b0;
    reset         = 1'b1;
    ex_kind       = rv_pkg::KIND_PLAIN;
    ex_taken      = 1'b0;
    ex_target     = '0;
    trace_len     = 0;
    k             = 0;
    cycle         = 0;
    last_retire   = 0;
    last_mp       = 1'b0;
    value_errors  = 0;
    timing_errors = 0;
    lcg_state     = SEED;
    load_trace();
    if (trace_len == 0) begin
      $display("could not read any trace entries from %s", STIM_FILE);
      print_counts();
      $display("TEST FAILED");
      $finish;
    end else begin
      trace_loaded = 1'b1;
      apply_reset();
      run_trace();
      print_counts();
      if (value_errors + timing_errors + UUT.u_props.fail_count == 0) begin
        $display("TEST OK");
      end else begin
        $display("TEST FAILED");
      end
      $finish;
    end
  end

  // watchdog, a trace needs at most 4 cycles per entry
  initial begin
    wait (trace_loaded);
    repeat (RESET_CYCLES + 4 * trace_len + 20) @(posedge clk);
    $display("trace did not finish, %0d of %0d entries retired before the time limit",
             k, trace_len);
    print_counts();
    $display("TEST FAILED");
    $finish;
  end

endmodule
